// ==== gc_cordic.f ====
+incdir+include
hw/cordic_pkg.sv
hw/req_capture.sv
hw/cordic_stage.sv
hw/cordic_pipe.sv
hw/dir_store.sv
hw/gain_comp.sv
hw/givens_top.sv
verif/tb_givens_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the Givens CORDIC testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
    --top-module tb_givens_top \
    -f gc_cordic.f \
    -o sim_givens

./obj_dir/sim_givens | tee sim.log

if grep -q "^sim passed$" sim.log; then
    echo "run_sim: PASS"
else
    echo "run_sim: FAIL"
    exit 1
fi

// ==== include/givens_tb_lib.svh ====
`ifndef GIVENS_TB_LIB_SVH
`define GIVENS_TB_LIB_SVH

typedef logic signed [cordic_pkg::INT_W-1:0] ival_t;

localparam int          REF_ITER  = 14;
localparam longint      REF_GAIN  = 9949;            // 1/K in units of 2^-14.
localparam int          REF_FRAC  = 14;
localparam longint      REF_ROUND = longint'(1) << (REF_FRAC - 1);
localparam logic [15:0] LFSR_TAPS = 16'hB400;
localparam logic [15:0] LFSR_SEED = 16'd87;

int               check_cnt = 0;
int               err_cnt   = 0;
logic [15:0]      lfsr_q    = LFSR_SEED;
cordic_pkg::dir_t model_dir = '0;                    // model copy of the direction register.

function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_q = lfsr_next(lfsr_q);
        v      = {v[30:0], lfsr_q[0]};
    end
    return v;
endfunction

// magnitude below 2^15 keeps the 19-bit datapath clear of overflow.
function automatic logic signed [cordic_pkg::DATA_W-1:0] random_coord();
    logic [31:0]                          r;
    logic signed [cordic_pkg::DATA_W-1:0] v;
    r = rand_bits(16);
    v = {3'b000, r[14:0]};
    if (r[15]) begin
        v = -v;
    end
    return v;
endfunction

function automatic logic signed [cordic_pkg::DATA_W-1:0] gain_scale(input ival_t v);
    longint p;
    p = longint'(v) * REF_GAIN;
    p = (p + REF_ROUND) >>> REF_FRAC;
    return p[cordic_pkg::DATA_W-1:0];
endfunction

// runs the 14 micro-rotations one after the other and updates the model directions.
function automatic cordic_pkg::resp_t cordic_model(input cordic_pkg::req_t req);
    ival_t             x;
    ival_t             y;
    ival_t             xn;
    ival_t             yn;
    logic              minus;
    cordic_pkg::resp_t r;
    r = '0;
    if (req.valid) begin
        x = req.sample.x;
        y = req.sample.y;
        for (int k = 0; k < REF_ITER; k++) begin
            if (req.op == cordic_pkg::OP_VECTOR) begin
                minus        = x[cordic_pkg::INT_W-1] ^ y[cordic_pkg::INT_W-1];
                model_dir[k] = minus;
            end else begin
                minus = model_dir[k];
            end
            xn = minus ? x - (y >>> k) : x + (y >>> k);
            yn = minus ? y + (x >>> k) : y - (x >>> k);
            x  = xn;
            y  = yn;
        end
        r.valid    = 1'b1;
        r.sample.x = gain_scale(x);
        r.sample.y = gain_scale(y);
    end
    return r;
endfunction

task automatic check_sample(input cordic_pkg::sample_t got, input cordic_pkg::sample_t exp,
                            input string what);
    check_cnt++;
    if (got !== exp) begin
        err_cnt++;
        $display("ERROR at %0t ns: %s sample got (%0d, %0d) expected (%0d, %0d)",
                 $time, what, got.x, got.y, exp.x, exp.y);
    end
endtask

task automatic check_resp(input cordic_pkg::resp_t got, input cordic_pkg::resp_t exp,
                          input string what);
    check_cnt++;
    if (got.valid !== exp.valid) begin
        err_cnt++;
        $display("ERROR at %0t ns: %s valid got %b expected %b",
                 $time, what, got.valid, exp.valid);
    end else if (exp.valid) begin
        check_sample(got.sample, exp.sample, what);
    end
endtask

`endif

// ==== verif/tb_givens_top.sv ====
`timescale 1ns/1ps

module tb_givens_top;

    `include "givens_tb_lib.svh"

    localparam int CLK_PERIOD  = 10;
    localparam int RST_CYCLES  = 5;
    localparam int LATENCY     = 9;
    localparam int N_ROT0      = 8;
    localparam int N_VEC       = 24;
    localparam int N_PAIR      = 16;
    localparam int N_STREAM    = 200;
    localparam int GARB_ROUNDS = 4;
    localparam int GARB_SLOTS  = 5;
    localparam int TEST_CYCLES = RST_CYCLES + 4 + N_ROT0 + N_VEC + 2 * N_PAIR + N_STREAM
                               + GARB_ROUNDS * (GARB_SLOTS + 3) + 5 * (LATENCY + 3);
    localparam int WATCHDOG_NS = (TEST_CYCLES + 100) * CLK_PERIOD;

    logic              clk;
    logic              rst_n;
    cordic_pkg::req_t  req_i;
    cordic_pkg::resp_t resp_o;
    int                cyc         = 0;
    int                checked_cyc = -1;
    int                last_cyc    = 0;
    int                prop_err    = 0;
    cordic_pkg::resp_t exp_mem [int];                // expected response per cycle.
    cordic_pkg::resp_t obs_mem [int];

    givens_top i_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .req_i  (req_i),
        .resp_o (resp_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // each response is compared half a cycle after the edge that produced it.
    always @(negedge clk) begin
        if (rst_n) begin
            obs_mem[cyc] = resp_o;
            if (exp_mem.exists(cyc)) begin
                check_resp(resp_o, exp_mem[cyc], $sformatf("response at cycle %0d", cyc));
            end else begin
                check_resp(resp_o, '0, $sformatf("idle slot at cycle %0d", cyc));
            end
            checked_cyc = cyc;
        end
    end

    function automatic cordic_pkg::req_t make_req(input logic valid, input cordic_pkg::op_e op,
                                                  input cordic_pkg::sample_t s);
        cordic_pkg::req_t r;
        r.valid  = valid;
        r.op     = op;
        r.sample = s;
        return r;
    endfunction

    function automatic cordic_pkg::sample_t random_sample();
        cordic_pkg::sample_t s;
        s.x = random_coord();
        s.y = random_coord();
        return s;
    endfunction

    task automatic issue(input cordic_pkg::req_t req);
        @(posedge clk);
        #1;
        req_i    = req;
        last_cyc = cyc + LATENCY;                    // the sampling edge is the first stage.
        if (req.valid) begin
            exp_mem[last_cyc] = cordic_model(req);
        end
    endtask

    task automatic drain();
        issue(make_req(1'b0, cordic_pkg::OP_ROTATE, '0));
        wait (checked_cyc >= last_cyc);
    endtask

    task automatic test_reset_rotate();
        for (int i = 0; i < 4; i++) begin
            issue(make_req(1'b0, cordic_pkg::OP_ROTATE, '0));
        end
        for (int i = 0; i < N_ROT0; i++) begin
            issue(make_req(1'b1, cordic_pkg::OP_ROTATE, random_sample()));
        end
        drain();
    endtask

    task automatic test_vectoring();
        int first;
        int last_vec;
        int xa;
        int ya;
        first = 0;
        for (int i = 0; i < N_VEC; i++) begin
            issue(make_req(1'b1, cordic_pkg::OP_VECTOR, random_sample()));
            if (i == 0) begin
                first = last_cyc;
            end
        end
        last_vec = last_cyc;
        drain();
        for (int c = first; c <= last_vec; c++) begin
            xa = obs_mem[c].sample.x;
            ya = obs_mem[c].sample.y;
            xa = (xa < 0) ? -xa : xa;
            ya = (ya < 0) ? -ya : ya;
            if (ya > (xa >>> 10) + 16) begin
                prop_err++;
                $display("ERROR at %0t ns: vectoring residual y=%0d too large for |x|=%0d",
                         $time, ya, xa);
            end
        end
    endtask

    task automatic test_back_to_back();
        for (int i = 0; i < N_PAIR; i++) begin
            issue(make_req(1'b1, cordic_pkg::OP_VECTOR, random_sample()));
            issue(make_req(1'b1, cordic_pkg::OP_ROTATE, random_sample()));
        end
        drain();
    endtask

    task automatic test_mixed_stream();
        logic [31:0] r;
        for (int i = 0; i < N_STREAM; i++) begin
            r = rand_bits(3);
            if (r[2:1] == 2'b00) begin
                issue(make_req(1'b0, cordic_pkg::OP_ROTATE, '0));
            end else begin
                issue(make_req(1'b1, cordic_pkg::op_e'(r[0]), random_sample()));
            end
        end
        drain();
    endtask

    task automatic test_invalid_vectoring();
        logic [31:0] r;
        cordic_pkg::sample_t junk;
        for (int n = 0; n < GARB_ROUNDS; n++) begin
            issue(make_req(1'b1, cordic_pkg::OP_VECTOR, random_sample()));
            for (int j = 0; j < GARB_SLOTS; j++) begin
                r      = rand_bits(18);
                junk.x = r[17:0];
                r      = rand_bits(18);
                junk.y = r[17:0];
                issue(make_req(1'b0, cordic_pkg::OP_VECTOR, junk));
            end
            issue(make_req(1'b1, cordic_pkg::OP_ROTATE, random_sample()));
        end
        drain();
    endtask

    initial begin
        rst_n = 1'b0;
        req_i = '0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reset_rotate();
        test_vectoring();
        test_back_to_back();
        test_mixed_stream();
        test_invalid_vectoring();
        $display("checks: %0d, mismatches: %0d, property errors: %0d",
                 check_cnt, err_cnt, prop_err);
        if (err_cnt == 0 && prop_err == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("sim failed");
        $finish;
    end

endmodule

// ==== hw/givens_top.sv ====
`timescale 1ns/1ps

module givens_top (
    input  logic               clk,
    input  logic               rst_n,
    input  cordic_pkg::req_t   req_i,
    output cordic_pkg::resp_t  resp_o
);

    cordic_pkg::flow_t               cap_flow;
    cordic_pkg::flow_t               pipe_flow;
    cordic_pkg::dir_t                prod_dir;     // bits produced by the stages this cycle.
    cordic_pkg::dir_t                eff_dir;      // register with strobed slices forwarded.
    logic [cordic_pkg::STAGE_NUM-1:0] dir_strobe;

    req_capture i_req_capture (
        .clk    (clk),
        .rst_n  (rst_n),
        .req_i  (req_i),
        .flow_o (cap_flow)
    );

    cordic_pipe i_cordic_pipe (
        .clk          (clk),
        .rst_n        (rst_n),
        .flow_i       (cap_flow),
        .dir_i        (eff_dir),
        .flow_o       (pipe_flow),
        .dir_o        (prod_dir),
        .dir_strobe_o (dir_strobe)
    );

    dir_store i_dir_store (
        .clk          (clk),
        .rst_n        (rst_n),
        .dir_i        (prod_dir),
        .dir_strobe_i (dir_strobe),
        .dir_o        (eff_dir)
    );

    gain_comp i_gain_comp (
        .clk    (clk),
        .rst_n  (rst_n),
        .flow_i (pipe_flow),
        .resp_o (resp_o)
    );

endmodule

// ==== hw/gain_comp.sv ====
`timescale 1ns/1ps

module gain_comp (
    input  logic              clk,
    input  logic              rst_n,
    input  cordic_pkg::flow_t flow_i,
    output cordic_pkg::resp_t resp_o
);

    // signed sample times the unsigned gain with a zero sign bit in front.
    localparam int PROD_W = cordic_pkg::INT_W + $bits(cordic_pkg::GAIN_K) + 1;
    localparam logic signed [PROD_W-1:0] ROUND_BIT = 1 << (cordic_pkg::GAIN_FRAC - 1);

    logic                valid_q;
    cordic_pkg::sample_t sample_q;

    function automatic logic signed [cordic_pkg::DATA_W-1:0] scale_round(
        input logic signed [cordic_pkg::INT_W-1:0] v
    );
        logic signed [PROD_W-1:0] prod;
        logic signed [PROD_W-1:0] shifted;
        prod    = v * $signed({1'b0, cordic_pkg::GAIN_K});
        shifted = (prod + ROUND_BIT) >>> cordic_pkg::GAIN_FRAC;
        return shifted[cordic_pkg::DATA_W-1:0];
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= flow_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        sample_q.x <= scale_round(flow_i.isample.x);
        sample_q.y <= scale_round(flow_i.isample.y);
    end

    always_comb begin
        resp_o.valid  = valid_q;
        resp_o.sample = sample_q;
    end

endmodule

// ==== hw/dir_store.sv ====
`timescale 1ns/1ps

module dir_store (
    input  logic                             clk,
    input  logic                             rst_n,
    input  cordic_pkg::dir_t                 dir_i,
    input  logic [cordic_pkg::STAGE_NUM-1:0] dir_strobe_i,
    output cordic_pkg::dir_t                 dir_o
);

    cordic_pkg::dir_t dir_q;
    cordic_pkg::dir_t dir_eff;

    // each stage owns two bits, and a strobed stage replaces just its own pair.
    always_comb begin
        dir_eff = dir_q;
        for (int s = 0; s < cordic_pkg::STAGE_NUM; s++) begin
            if (dir_strobe_i[s]) begin
                dir_eff[2*s +: 2] = dir_i[2*s +: 2];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dir_q <= '0;
        end else begin
            dir_q <= dir_eff;
        end
    end

    assign dir_o = dir_eff;                      // new bits are visible in the same cycle.

endmodule

// ==== hw/cordic_pipe.sv ====
`timescale 1ns/1ps

module cordic_pipe (
    input  logic                             clk,
    input  logic                             rst_n,
    input  cordic_pkg::flow_t                flow_i,
    input  cordic_pkg::dir_t                 dir_i,
    output cordic_pkg::flow_t                flow_o,
    output cordic_pkg::dir_t                 dir_o,
    output logic [cordic_pkg::STAGE_NUM-1:0] dir_strobe_o
);

    // chain[s] is the item entering stage s and chain[STAGE_NUM] leaves the last one.
    cordic_pkg::flow_t chain [0:cordic_pkg::STAGE_NUM];

    assign chain[0] = flow_i;
    assign flow_o   = chain[cordic_pkg::STAGE_NUM];

    for (genvar g = 0; g < cordic_pkg::STAGE_NUM; g++) begin : g_stage
        cordic_pkg::dir_slice_t slice_in;
        cordic_pkg::dir_slice_t slice_out;

        assign slice_in = dir_i[2*g +: 2];

        cordic_stage #(
            .STAGE (g)
        ) i_cordic_stage (
            .clk    (clk),
            .rst_n  (rst_n),
            .flow_i (chain[g]),
            .dir_i  (slice_in),
            .flow_o (chain[g+1]),
            .dir_o  (slice_out)
        );

        assign dir_o[2*g +: 2] = slice_out;

        // only a real vectoring item may overwrite the stored directions.
        assign dir_strobe_o[g] = chain[g].valid && (chain[g].op == cordic_pkg::OP_VECTOR);
    end

endmodule

// ==== hw/cordic_stage.sv ====
`timescale 1ns/1ps

module cordic_stage #(
    parameter int STAGE = 0
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cordic_pkg::flow_t      flow_i,
    input  cordic_pkg::dir_slice_t dir_i,
    output cordic_pkg::flow_t      flow_o,
    output cordic_pkg::dir_slice_t dir_o
);

    localparam int SHIFT0 = 2 * STAGE;
    localparam int SHIFT1 = 2 * STAGE + 1;

    cordic_pkg::isample_t vec_mid;
    cordic_pkg::isample_t rot_mid;
    cordic_pkg::isample_t mid;
    cordic_pkg::isample_t result;
    logic                 is_vector;
    logic                 vec_d0;
    logic                 vec_d1;
    logic                 d1;
    logic                 valid_q;
    cordic_pkg::op_e      op_q;
    cordic_pkg::isample_t isample_q;

    function automatic cordic_pkg::isample_t micro_rot(input cordic_pkg::isample_t s,
                                                       input logic                 minus,
                                                       input int                   shift);
        cordic_pkg::isample_t r;
        if (minus) begin
            r.x = s.x - (s.y >>> shift);
            r.y = s.y + (s.x >>> shift);
        end else begin
            r.x = s.x + (s.y >>> shift);
            r.y = s.y - (s.x >>> shift);
        end
        return r;
    endfunction

    function automatic logic signs_differ(input cordic_pkg::isample_t s);
        return s.x[cordic_pkg::INT_W-1] ^ s.y[cordic_pkg::INT_W-1];
    endfunction

    // the vectoring path never looks at dir_i, so dir_o stays free of the forwarding loop.
    always_comb begin
        is_vector = (flow_i.op == cordic_pkg::OP_VECTOR);
        vec_d0    = signs_differ(flow_i.isample);
        vec_mid   = micro_rot(flow_i.isample, vec_d0, SHIFT0);
        vec_d1    = signs_differ(vec_mid);
        rot_mid   = micro_rot(flow_i.isample, dir_i[0], SHIFT0);
        mid       = is_vector ? vec_mid : rot_mid;
        d1        = is_vector ? vec_d1 : dir_i[1];
        result    = micro_rot(mid, d1, SHIFT1);
    end

    assign dir_o = is_vector ? {vec_d1, vec_d0} : 2'b00;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            op_q    <= cordic_pkg::OP_ROTATE;
        end else begin
            valid_q <= flow_i.valid;
            op_q    <= flow_i.op;
        end
    end

    always_ff @(posedge clk) begin
        isample_q <= result;
    end

    always_comb begin
        flow_o.valid   = valid_q;
        flow_o.op      = op_q;
        flow_o.isample = isample_q;
    end

endmodule

// ==== hw/req_capture.sv ====
`timescale 1ns/1ps

module req_capture (
    input  logic              clk,
    input  logic              rst_n,
    input  cordic_pkg::req_t  req_i,
    output cordic_pkg::flow_t flow_o
);

    localparam int EXT_W = cordic_pkg::INT_W - cordic_pkg::DATA_W;

    logic                 valid_q;
    cordic_pkg::op_e      op_q;
    cordic_pkg::isample_t isample_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            op_q    <= cordic_pkg::OP_ROTATE;
        end else begin
            valid_q <= req_i.valid;
            // an idle slot must never look like vectoring further down.
            op_q    <= req_i.valid ? req_i.op : cordic_pkg::OP_ROTATE;
        end
    end

    always_ff @(posedge clk) begin
        isample_q.x <= {{EXT_W{req_i.sample.x[cordic_pkg::DATA_W-1]}}, req_i.sample.x};
        isample_q.y <= {{EXT_W{req_i.sample.y[cordic_pkg::DATA_W-1]}}, req_i.sample.y};
    end

    always_comb begin
        flow_o.valid   = valid_q;
        flow_o.op      = op_q;
        flow_o.isample = isample_q;
    end

endmodule

// ==== hw/cordic_pkg.sv ====
package cordic_pkg;

    localparam int DATA_W    = 18;
    localparam int INT_W     = DATA_W + 1;       // one guard bit for CORDIC growth.
    localparam int ITER_NUM  = 14;
    localparam int STAGE_NUM = ITER_NUM / 2;     // two micro-rotations per stage.

    // 1/K of the 14 micro-rotations is 9949 in units of 2^-14.
    localparam logic [14:0] GAIN_K    = 15'b010011011011101;
    localparam int          GAIN_FRAC = 14;

    typedef enum logic {
        OP_VECTOR = 1'b0,
        OP_ROTATE = 1'b1
    } op_e;

    typedef logic [ITER_NUM-1:0] dir_t;          // bit k set means "minus" form at step k.
    typedef logic [1:0]          dir_slice_t;

    typedef struct packed {
        logic signed [DATA_W-1:0] x;
        logic signed [DATA_W-1:0] y;
    } sample_t;

    typedef struct packed {
        logic signed [INT_W-1:0] x;
        logic signed [INT_W-1:0] y;
    } isample_t;

    typedef struct packed {
        logic    valid;
        op_e     op;
        sample_t sample;
    } req_t;

    typedef struct packed {
        logic    valid;
        sample_t sample;
    } resp_t;

    typedef struct packed {
        logic     valid;
        op_e      op;
        isample_t isample;
    } flow_t;

endpackage
